//--- hdl/pifo_geom_pkg.sv
package pifo_geom_pkg;

    // ----------------------------------------------------------------------
    // Tree shape
    // ----------------------------------------------------------------------
    localparam int NUM_LEVELS = 3;
    localparam int FANOUT     = 4;      // Slots per node
    localparam int NODE_IDX_W = 4;      // Wide enough for the 16 leaf nodes

    // ----------------------------------------------------------------------
    // Node memory
    // ----------------------------------------------------------------------
    localparam int NUM_NODES  = 21;     // 1 + 4 + 16
    localparam int MEM_ADDR_W = 5;

    // First node address of each level, level 0 in the lowest field
    localparam logic [NUM_LEVELS-1:0][MEM_ADDR_W-1:0] LEVEL_BASE = {
        5'd5,
        5'd1,
        5'd0
    };

    // ----------------------------------------------------------------------
    // Occupancy and command spacing
    // ----------------------------------------------------------------------
    localparam int CAPACITY = 84;       // Every slot of every node
    localparam int OCC_W    = 7;

    // Each level needs its read, select and commit cycle before the next
    // command may reach it
    localparam int CMD_GAP = NUM_LEVELS;

endpackage

//--- hdl/pifo_node_pkg.sv
package pifo_node_pkg;

    // ----------------------------------------------------------------------
    // Entry and slot layout
    // ----------------------------------------------------------------------
    localparam int PRIO_W  = 12;
    localparam int TAG_W   = 4;                 // Carried along, never compared
    localparam int ENTRY_W = TAG_W + PRIO_W;    // {tag, prio}
    localparam int CNT_W   = 5;                 // Up to 21 entries below a root slot
    localparam int SLOT_W  = CNT_W + ENTRY_W;   // {count, tag, prio}

    // Four slots per node word, slot 0 in the low bits
    localparam int NODE_W     = 4 * SLOT_W;
    localparam int SLOT_IDX_W = 2;

    // All-ones priority marks a free slot
    localparam logic [PRIO_W-1:0]  EMPTY_PRIO  = '1;
    localparam logic [ENTRY_W-1:0] EMPTY_ENTRY = {{TAG_W{1'b0}}, EMPTY_PRIO};

    // ----------------------------------------------------------------------
    // Level commands and engine FSM
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_NONE,
        OP_PUSH,
        OP_POP
    } op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SELECT,      // Node word on the read bus
        ST_COMMIT       // Updated node written back
    } state_e;

endpackage

//--- hdl/pifo_min_select.sv
`timescale 1ns/10ps

module pifo_min_select
    import pifo_geom_pkg::*;
    import pifo_node_pkg::*;
(
    input  logic [NODE_W-1:0]     i_node,
    output logic [SLOT_IDX_W-1:0] o_min_cnt_slot,   // Lightest subtree
    output logic [SLOT_IDX_W-1:0] o_min_prio_slot   // Smallest entry
);

    logic [CNT_W-1:0]  best_cnt;
    logic [PRIO_W-1:0] best_prio;
    logic [CNT_W-1:0]  cur_cnt;
    logic [PRIO_W-1:0] cur_prio;

    // Strict compare keeps the lowest slot on a tie
    always_comb begin
        best_cnt        = i_node[ENTRY_W +: CNT_W];
        best_prio       = i_node[0 +: PRIO_W];
        o_min_cnt_slot  = '0;
        o_min_prio_slot = '0;
        cur_cnt         = '0;
        cur_prio        = '0;
        for (int i = 1; i < FANOUT; i++) begin
            cur_cnt  = i_node[i*SLOT_W + ENTRY_W +: CNT_W];
            cur_prio = i_node[i*SLOT_W +: PRIO_W];
            if (cur_cnt < best_cnt) begin
                best_cnt       = cur_cnt;
                o_min_cnt_slot = SLOT_IDX_W'(i);
            end
            if (cur_prio < best_prio) begin
                best_prio       = cur_prio;
                o_min_prio_slot = SLOT_IDX_W'(i);
            end
        end
    end

endmodule

//--- hdl/pifo_level_engine.sv
`timescale 1ns/10ps

module pifo_level_engine
    import pifo_geom_pkg::*;
    import pifo_node_pkg::*;
#(
    parameter int LEVEL_IDX = 0
) (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    // From parent level
    input  op_e                   i_cmd,
    input  logic [ENTRY_W-1:0]    i_cmd_entry,
    input  logic [NODE_IDX_W-1:0] i_node_idx,
    // To child level
    output op_e                   o_child_cmd,
    output logic [ENTRY_W-1:0]    o_child_entry,
    output logic [NODE_IDX_W-1:0] o_child_idx,
    // Refill path, child to parent
    input  logic [ENTRY_W-1:0]    i_refill_entry,
    output logic [ENTRY_W-1:0]    o_refill_entry,
    // Node memory
    output logic                  o_rd_req,
    output logic [MEM_ADDR_W-1:0] o_rd_addr,
    input  logic [NODE_W-1:0]     i_rd_node,
    output logic                  o_wr_req,
    output logic [MEM_ADDR_W-1:0] o_wr_addr,
    output logic [NODE_W-1:0]     o_wr_node
);

    localparam logic [MEM_ADDR_W-1:0] BASE = LEVEL_BASE[LEVEL_IDX];
    localparam bit IS_LAST = (LEVEL_IDX == NUM_LEVELS - 1);   // No child below

    state_e                  state_q;
    op_e                     cmd_q;
    logic [ENTRY_W-1:0]      entry_q;
    logic [NODE_IDX_W-1:0]   idx_q;
    logic [NODE_W-1:0]       node_q;
    logic [SLOT_IDX_W-1:0]   slot_q;

    logic                    accept;
    logic [SLOT_IDX_W-1:0]   min_cnt_slot;
    logic [SLOT_IDX_W-1:0]   min_prio_slot;
    logic [SLOT_IDX_W-1:0]   sel_slot;
    logic [ENTRY_W-1:0]      sel_entry;
    logic [ENTRY_W-1:0]      min_entry;
    logic                    slot_empty;
    logic                    keep_new;

    logic [CNT_W-1:0]        old_cnt;
    logic [ENTRY_W-1:0]      old_entry;
    logic [CNT_W-1:0]        new_cnt;
    logic [ENTRY_W-1:0]      new_entry;

    pifo_min_select u_min_select (
        .i_node          (i_rd_node),
        .o_min_cnt_slot  (min_cnt_slot),
        .o_min_prio_slot (min_prio_slot)
    );

    // ----------------------------------------------------------------------
    // FSM and command capture
    // ----------------------------------------------------------------------
    assign accept = (i_cmd != OP_NONE) && (state_q != ST_SELECT);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ST_IDLE;
            cmd_q   <= OP_NONE;
        end else begin
            case (state_q)
                ST_SELECT: state_q <= ST_COMMIT;
                default:   state_q <= accept ? ST_SELECT : ST_IDLE;
            endcase
            if (accept) begin
                cmd_q <= i_cmd;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            entry_q <= i_cmd_entry;
            idx_q   <= i_node_idx;
        end
        if (state_q == ST_SELECT) begin
            node_q <= i_rd_node;    // Kept for the write-back
            slot_q <= sel_slot;
        end
    end

    // ----------------------------------------------------------------------
    // Select cycle
    // ----------------------------------------------------------------------
    assign sel_slot   = (cmd_q == OP_PUSH) ? min_cnt_slot : min_prio_slot;
    assign sel_entry  = i_rd_node[sel_slot*SLOT_W +: ENTRY_W];
    assign min_entry  = i_rd_node[min_prio_slot*SLOT_W +: ENTRY_W];
    assign slot_empty = (sel_entry[PRIO_W-1:0] == EMPTY_PRIO);
    assign keep_new   = (entry_q[PRIO_W-1:0] < sel_entry[PRIO_W-1:0]);

    always_comb begin
        o_child_cmd = OP_NONE;
        if (state_q == ST_SELECT && !IS_LAST) begin
            if (cmd_q == OP_POP) begin
                o_child_cmd = OP_POP;
            end else if (!slot_empty) begin
                o_child_cmd = OP_PUSH;          // Larger entry sinks
            end
        end
    end

    assign o_child_entry = keep_new ? sel_entry : entry_q;
    assign o_child_idx   = {idx_q[NODE_IDX_W-SLOT_IDX_W-1:0], sel_slot};  // 4*idx + slot

    // Parent samples this only in its commit cycle
    assign o_refill_entry = (state_q == ST_SELECT) ? min_entry : EMPTY_ENTRY;

    // ----------------------------------------------------------------------
    // Commit cycle
    // ----------------------------------------------------------------------
    always_comb begin
        old_cnt   = node_q[slot_q*SLOT_W + ENTRY_W +: CNT_W];
        old_entry = node_q[slot_q*SLOT_W +: ENTRY_W];
        if (cmd_q == OP_PUSH) begin
            new_cnt   = old_cnt + 1'b1;
            new_entry = (entry_q[PRIO_W-1:0] < old_entry[PRIO_W-1:0]) ? entry_q : old_entry;
        end else begin
            new_cnt   = (old_cnt != '0) ? old_cnt - 1'b1 : old_cnt;
            new_entry = i_refill_entry;         // Child minimum moves up
        end
        o_wr_node = node_q;
        o_wr_node[slot_q*SLOT_W +: SLOT_W] = {new_cnt, new_entry};
    end

    assign o_rd_req  = accept;
    assign o_rd_addr = BASE + MEM_ADDR_W'(i_node_idx);
    assign o_wr_req  = (state_q == ST_COMMIT);
    assign o_wr_addr = BASE + MEM_ADDR_W'(idx_q);

endmodule

//--- hdl/pifo_node_store.sv
`timescale 1ns/10ps

module pifo_node_store
    import pifo_geom_pkg::*;
    import pifo_node_pkg::*;
(
    input  logic                             i_clk,
    input  logic                             i_arst_n,
    input  logic [NUM_LEVELS-1:0]            i_rd_req,
    input  logic [NUM_LEVELS*MEM_ADDR_W-1:0] i_rd_addr,
    output logic [NODE_W-1:0]                o_rd_node,
    input  logic [NUM_LEVELS-1:0]            i_wr_req,
    input  logic [NUM_LEVELS*MEM_ADDR_W-1:0] i_wr_addr,
    input  logic [NUM_LEVELS*NODE_W-1:0]     i_wr_node
);

    localparam logic [SLOT_W-1:0] EMPTY_SLOT = {{CNT_W{1'b0}}, EMPTY_ENTRY};
    localparam logic [NODE_W-1:0] EMPTY_NODE = {FANOUT{EMPTY_SLOT}};

    logic [NODE_W-1:0]     mem [NUM_NODES];
    logic                  rd_any;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic                  wr_any;
    logic [MEM_ADDR_W-1:0] wr_addr;
    logic [NODE_W-1:0]     wr_node;

    // Fixed priority, level 0 wins; walk down so the lowest requester is last
    always_comb begin
        rd_any  = 1'b0;
        rd_addr = '0;
        wr_any  = 1'b0;
        wr_addr = '0;
        wr_node = '0;
        for (int i = NUM_LEVELS - 1; i >= 0; i--) begin
            if (i_rd_req[i]) begin
                rd_any  = 1'b1;
                rd_addr = i_rd_addr[i*MEM_ADDR_W +: MEM_ADDR_W];
            end
            if (i_wr_req[i]) begin
                wr_any  = 1'b1;
                wr_addr = i_wr_addr[i*MEM_ADDR_W +: MEM_ADDR_W];
                wr_node = i_wr_node[i*NODE_W +: NODE_W];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                mem[n] <= EMPTY_NODE;
            end
        end else if (wr_any) begin
            mem[wr_addr] <= wr_node;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_any) begin
            o_rd_node <= mem[rd_addr];  // Shared by all engines
        end
    end

endmodule

//--- hdl/pifo_top.sv
`timescale 1ns/10ps

module pifo_top
    import pifo_geom_pkg::*;
    import pifo_node_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_push,
    input  logic [ENTRY_W-1:0] i_push_data,
    input  logic               i_pop,
    output logic               o_pop_valid,
    output logic [ENTRY_W-1:0] o_pop_data
);

    op_e                             root_cmd;
    logic [OCC_W-1:0]                occ_q;
    logic                            pop_pend_q;    // Root is in its select cycle

    // Level k feeds element k+1; the last element is the bottom edge
    op_e                             lvl_cmd    [NUM_LEVELS+1];
    logic [ENTRY_W-1:0]              lvl_entry  [NUM_LEVELS+1];
    logic [NODE_IDX_W-1:0]           lvl_idx    [NUM_LEVELS+1];
    logic [ENTRY_W-1:0]              lvl_refill [NUM_LEVELS+1];

    logic [NUM_LEVELS-1:0]           rd_req;
    logic [NUM_LEVELS*MEM_ADDR_W-1:0] rd_addr;
    logic [NODE_W-1:0]               rd_node;
    logic [NUM_LEVELS-1:0]           wr_req;
    logic [NUM_LEVELS*MEM_ADDR_W-1:0] wr_addr;
    logic [NUM_LEVELS*NODE_W-1:0]    wr_node;

    // Push with pop is ignored, push into a full queue is dropped
    always_comb begin
        root_cmd = OP_NONE;
        if (i_push && !i_pop && (occ_q < OCC_W'(CAPACITY))) begin
            root_cmd = OP_PUSH;
        end else if (i_pop && !i_push) begin
            root_cmd = OP_POP;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            occ_q       <= '0;
            pop_pend_q  <= 1'b0;
            o_pop_valid <= 1'b0;
        end else begin
            if (root_cmd == OP_PUSH) begin
                occ_q <= occ_q + 1'b1;
            end else if (root_cmd == OP_POP && occ_q != '0) begin
                occ_q <= occ_q - 1'b1;
            end
            pop_pend_q  <= (root_cmd == OP_POP);
            o_pop_valid <= pop_pend_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (pop_pend_q) begin
            o_pop_data <= lvl_refill[0];    // Root minimum
        end
    end

    // ----------------------------------------------------------------------
    // Level engines
    // ----------------------------------------------------------------------
    assign lvl_cmd[0]             = root_cmd;
    assign lvl_entry[0]           = i_push_data;
    assign lvl_idx[0]             = '0;
    assign lvl_refill[NUM_LEVELS] = EMPTY_ENTRY;    // Nothing below the leaves

    for (genvar k = 0; k < NUM_LEVELS; k++) begin : g_level
        pifo_level_engine #(
            .LEVEL_IDX (k)
        ) u_engine (
            .i_clk          (i_clk),
            .i_arst_n       (i_arst_n),
            .i_cmd          (lvl_cmd[k]),
            .i_cmd_entry    (lvl_entry[k]),
            .i_node_idx     (lvl_idx[k]),
            .o_child_cmd    (lvl_cmd[k+1]),
            .o_child_entry  (lvl_entry[k+1]),
            .o_child_idx    (lvl_idx[k+1]),
            .i_refill_entry (lvl_refill[k+1]),
            .o_refill_entry (lvl_refill[k]),
            .o_rd_req       (rd_req[k]),
            .o_rd_addr      (rd_addr[k*MEM_ADDR_W +: MEM_ADDR_W]),
            .i_rd_node      (rd_node),
            .o_wr_req       (wr_req[k]),
            .o_wr_addr      (wr_addr[k*MEM_ADDR_W +: MEM_ADDR_W]),
            .o_wr_node      (wr_node[k*NODE_W +: NODE_W])
        );
    end

    pifo_node_store u_store (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rd_req  (rd_req),
        .i_rd_addr (rd_addr),
        .o_rd_node (rd_node),
        .i_wr_req  (wr_req),
        .i_wr_addr (wr_addr),
        .i_wr_node (wr_node)
    );

endmodule

//--- verification/pifo_props.sv
`timescale 1ns/10ps

module pifo_props
    import pifo_geom_pkg::*;
(
    input logic                  i_clk,
    input logic                  i_arst_n,
    input logic                  i_push,
    input logic                  i_pop,
    input logic [NUM_LEVELS-1:0] i_rd_req,
    input logic [NUM_LEVELS-1:0] i_wr_req,
    input logic                  i_pop_valid
);

    logic [3:0] since_q;    // Cycles since the last strobe, saturating

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            since_q <= 4'(CMD_GAP);
        end else if (i_push || i_pop) begin
            since_q <= 4'd1;
        end else if (since_q < 4'(CMD_GAP)) begin
            since_q <= since_q + 4'd1;
        end
    end

    // Store ports never see two levels at once
    a_rd_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0(i_rd_req))
        else $error("More than one level requested a node read");

    a_wr_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0(i_wr_req))
        else $error("More than one level requested a node write");

    a_cmd_gap: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_push || i_pop) |-> (since_q >= 4'(CMD_GAP)))
        else $error("External strobes closer than the command gap");

    a_pop_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pop_valid |=> !i_pop_valid)
        else $error("o_pop_valid held for more than one cycle");

endmodule

// Request lines of the store as seen in the top
bind pifo_top pifo_props u_props (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_push      (i_push),
    .i_pop       (i_pop),
    .i_rd_req    (rd_req),
    .i_wr_req    (wr_req),
    .i_pop_valid (o_pop_valid)
);

//--- verification/pifo_tb.sv
`timescale 1ns/10ps

module pifo_tb
    import pifo_geom_pkg::*;
    import pifo_node_pkg::*;
();

    localparam int          CLK_HALF    = 2;
    localparam int          RST_CYCLES  = 8;
    localparam int          N_CMDS      = 600;
    localparam int          N_FIRST     = 50;
    localparam int          N_OVERFILL  = 10;
    localparam int          N_TIE_PUSH  = 3;
    localparam int          N_RANDOM    = N_CMDS - 2 * N_FIRST - (CAPACITY + N_OVERFILL)
                                          - (CAPACITY + 1) - (2 * N_TIE_PUSH + 2);
    localparam int          POP_LAT     = 2;
    localparam int          POP_WAIT    = 8;    // Give up on a missing o_pop_valid
    localparam int          WATCHDOG_NS = N_CMDS * CMD_GAP * 2 * CLK_HALF + 2000;
    localparam logic [15:0] SEED        = 16'd43;
    localparam logic [15:0] LFSR_POLY   = 16'hB400;

    logic               clk;
    logic               arst_n;
    logic               push;
    logic               pop;
    logic [ENTRY_W-1:0] push_data;
    logic               pop_valid;
    logic [ENTRY_W-1:0] pop_data;

    logic [15:0]        lfsr_state;
    logic [ENTRY_W-1:0] model_q[$];     // Unordered list of stored entries
    logic [ENTRY_W-1:0] last_pop;
    logic [PRIO_W-1:0]  last_prio;
    bit                 check_order;
    int                 mismatch_cnt;
    int                 fail_cnt;
    int                 pop_cnt;
    int                 drained;

    pifo_top u_dut (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_push      (push),
        .i_push_data (push_data),
        .i_pop       (pop),
        .o_pop_valid (pop_valid),
        .o_pop_data  (pop_data)
    );

    always #CLK_HALF clk = ~clk;

    // ----------------------------------------------------------------------
    // Stimulus source
    // ----------------------------------------------------------------------
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        logic        b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ LFSR_POLY;
            end
            val = {val[14:0], b};
        end
        return val;
    endfunction

    function automatic logic [ENTRY_W-1:0] rand_entry();
        logic [PRIO_W-1:0] prio;
        logic [TAG_W-1:0]  tag;
        prio = PRIO_W'(rand_bits(PRIO_W));
        if (prio == '1) begin
            prio = prio - 1'b1;     // All-ones is reserved for empty
        end
        tag = TAG_W'(rand_bits(TAG_W));
        return {tag, prio};
    endfunction

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    task automatic model_push(input logic [ENTRY_W-1:0] e);
        if (model_q.size() < CAPACITY) begin
            model_q.push_back(e);   // Full queue drops it
        end
    endtask

    task automatic check_pop(input logic [ENTRY_W-1:0] got);
        logic [PRIO_W-1:0] exp_prio;
        int                min_idx;
        int                hit_idx;
        exp_prio = '1;
        min_idx  = -1;
        hit_idx  = -1;
        pop_cnt++;
        foreach (model_q[i]) begin
            if (model_q[i][PRIO_W-1:0] < exp_prio) begin
                exp_prio = model_q[i][PRIO_W-1:0];
                min_idx  = i;
            end
        end
        if (got[PRIO_W-1:0] != exp_prio) begin
            mismatch_cnt++;
            $display("mismatch o_pop_data prio: got %h expected %h", got[PRIO_W-1:0], exp_prio);
        end else if (min_idx >= 0) begin
            // Any entry of the tied priority may come out
            foreach (model_q[i]) begin
                if (hit_idx < 0 && model_q[i] == got) begin
                    hit_idx = i;
                end
            end
            if (hit_idx < 0) begin
                mismatch_cnt++;
                $display("mismatch o_pop_data tag: got %h expected %h",
                         got[ENTRY_W-1:PRIO_W], model_q[min_idx][ENTRY_W-1:PRIO_W]);
                hit_idx = min_idx;
            end
            model_q.delete(hit_idx);
        end
        if (check_order && got[PRIO_W-1:0] < last_prio) begin
            mismatch_cnt++;
            $display("mismatch o_pop_data order: got %h after %h", got[PRIO_W-1:0], last_prio);
        end
        last_prio = got[PRIO_W-1:0];
    endtask

    // ----------------------------------------------------------------------
    // One command held apart from the next by CMD_GAP cycles
    // ----------------------------------------------------------------------
    task automatic run_cmd(input logic do_push, input logic do_pop,
                           input logic [ENTRY_W-1:0] data);
        bit exp_valid;
        bit got_valid;
        int cyc;
        int lat;
        exp_valid = do_pop && !do_push;
        got_valid = 1'b0;
        lat       = 0;
        last_pop  = '1;
        @(posedge clk);
        #1;
        push      = do_push;
        pop       = do_pop;
        push_data = data;
        if (do_push && !do_pop) begin
            model_push(data);
        end
        for (cyc = 0; cyc < CMD_GAP || (exp_valid && !got_valid && cyc <= POP_WAIT); cyc++) begin
            if (cyc > 0) begin
                @(posedge clk);
                #1;
                push = 1'b0;
                pop  = 1'b0;
            end
            @(negedge clk);
            if (pop_valid) begin
                if (got_valid || !exp_valid) begin
                    fail_cnt++;
                    $display("o_pop_valid rose with no pop waiting, cycle %0d of a command", cyc);
                end else begin
                    got_valid = 1'b1;
                    lat       = cyc;
                    last_pop  = pop_data;
                end
            end
        end
        if (exp_valid && !got_valid) begin
            fail_cnt++;
            $display("No o_pop_valid within %0d cycles of a pop", POP_WAIT);
        end else if (got_valid) begin
            if (lat != POP_LAT) begin
                mismatch_cnt++;
                $display("mismatch o_pop_valid latency: got %h expected %h", lat, POP_LAT);
            end
            check_pop(last_pop);
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d mismatches, %0d other errors, %0d pops checked",
                 mismatch_cnt, fail_cnt, pop_cnt);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [1:0]         sel;
        logic [ENTRY_W-1:0] ent;
        clk          = 1'b0;
        arst_n       = 1'b0;
        push         = 1'b0;
        pop          = 1'b0;
        push_data    = '0;
        lfsr_state   = SEED;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        pop_cnt      = 0;
        drained      = 0;
        check_order  = 1'b0;
        last_prio    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        if (pop_valid !== 1'b0) begin
            mismatch_cnt++;
            $display("mismatch o_pop_valid after reset: got %h expected %h",
                     pop_valid, 1'b0);
        end

        // Sorted readout
        for (int i = 0; i < N_FIRST; i++) begin
            run_cmd(1'b1, 1'b0, rand_entry());
        end
        check_order = 1'b1;
        for (int i = 0; i < N_FIRST; i++) begin
            run_cmd(1'b0, 1'b1, rand_entry());
        end
        check_order = 1'b0;

        // Random mix
        for (int i = 0; i < N_RANDOM; i++) begin
            sel = 2'(rand_bits(2));
            ent = rand_entry();
            case (sel)
                2'd0:    run_cmd(1'b0, 1'b0, ent);  // Idle
                2'd1:    run_cmd(1'b0, 1'b1, ent);
                default: run_cmd(1'b1, 1'b0, ent);
            endcase
        end

        // Overfill and then drain one past empty
        for (int i = 0; i < CAPACITY + N_OVERFILL; i++) begin
            run_cmd(1'b1, 1'b0, rand_entry());
        end
        for (int i = 0; i < CAPACITY + 1; i++) begin
            run_cmd(1'b0, 1'b1, rand_entry());
            if (last_pop[PRIO_W-1:0] != '1) begin
                drained++;
            end
        end
        if (drained != CAPACITY) begin
            fail_cnt++;
            $display("Drain returned %0d entries instead of %0d", drained, CAPACITY);
        end

        // Push and pop in the same cycle
        for (int i = 0; i < N_TIE_PUSH; i++) begin
            run_cmd(1'b1, 1'b0, rand_entry());
        end
        run_cmd(1'b1, 1'b1, rand_entry());
        for (int i = 0; i < N_TIE_PUSH + 1; i++) begin
            run_cmd(1'b0, 1'b1, rand_entry());
        end

        print_summary();
        if (mismatch_cnt + fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with the test still running", WATCHDOG_NS);
        print_summary();
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- pifo_sram.f
hdl/pifo_geom_pkg.sv
hdl/pifo_node_pkg.sv
hdl/pifo_min_select.sv
hdl/pifo_level_engine.sv
hdl/pifo_node_store.sv
hdl/pifo_top.sv
verification/pifo_props.sv
verification/pifo_tb.sv

//--- Bender.yml
package:
  name: pifo_sram

sources:
  # Design, packages first
  - files:
      - hdl/pifo_geom_pkg.sv
      - hdl/pifo_node_pkg.sv
      - hdl/pifo_min_select.sv
      - hdl/pifo_level_engine.sv
      - hdl/pifo_node_store.sv
      - hdl/pifo_top.sv

  # Verification
  - target: test
    files:
      - verification/pifo_props.sv
      - verification/pifo_tb.sv
